/* Bender.yml */
package:
  name: dsp_fracturable

sources:
  - files:
      - logic/dsp_pkg.sv
      - logic/dsp_operand_stage.sv
      - logic/dsp_mac_accumulator.sv
      - logic/dsp_output_stage.sv
      - logic/dsp_slice.sv
      - logic/dsp_fracturable.sv
  - target: simulation
    files:
      - sim/tb_dsp_fracturable.sv

/* build.f */
logic/dsp_pkg.sv
logic/dsp_operand_stage.sv
logic/dsp_mac_accumulator.sv
logic/dsp_output_stage.sv
logic/dsp_slice.sv
logic/dsp_fracturable.sv
sim/tb_dsp_fracturable.sv

/* logic/dsp_fracturable.sv */
`timescale 1ns/1ps

module dsp_fracturable #(
    parameter logic [dsp_pkg::NBITS_COEF-1:0] COEFF_0 = '0,
    parameter logic [dsp_pkg::NBITS_COEF-1:0] COEFF_1 = '0,
    parameter logic [dsp_pkg::NBITS_COEF-1:0] COEFF_2 = '0,
    parameter logic [dsp_pkg::NBITS_COEF-1:0] COEFF_3 = '0
) (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic [dsp_pkg::NBITS_A-1:0]  a_i,
    input  logic [dsp_pkg::NBITS_B-1:0]  b_i,
    input  logic [dsp_pkg::NBITS_AF-1:0] acc_fir_i,
    input  dsp_pkg::dsp_ctrl_t           ctrl_i,
    input  logic                         f_mode_i,
    output dsp_pkg::dsp_z_u              z_o,
    output dsp_pkg::dsp_dly_b_u          dly_b_o
);
    import dsp_pkg::*;

    localparam int A_H    = NBITS_A / 2;
    localparam int B_H    = NBITS_B / 2;
    localparam int Z_H    = NBITS_Z / 2;
    localparam int ACC_H  = NBITS_ACC / 2;
    localparam int COEF_H = NBITS_COEF / 2;
    localparam int AF_H   = NBITS_AF / 2;

    logic [NBITS_Z-1:0] full_z;
    logic [Z_H-1:0]     frac0_z;
    logic [Z_H-1:0]     frac1_z;
    logic [NBITS_B-1:0] full_dly_b;
    logic [B_H-1:0]     frac0_dly_b;
    logic [B_H-1:0]     frac1_dly_b;

    dsp_slice #(
        .NBITS_A (NBITS_A), .NBITS_B (NBITS_B), .NBITS_ACC (NBITS_ACC),
        .NBITS_Z (NBITS_Z), .NBITS_COEF (NBITS_COEF), .NBITS_AF (NBITS_AF),
        .COEF_0 (COEFF_0), .COEF_1 (COEFF_1), .COEF_2 (COEFF_2), .COEF_3 (COEFF_3)
    ) u_full (
        .clock_i (clk), .reset_i (reset_i), .a_i (a_i), .b_i (b_i),
        .acc_fir_i (acc_fir_i), .ctrl_i (ctrl_i), .z_o (full_z), .dly_b_o (full_dly_b)
    );

    // Low halves of every operand and coefficient.
    dsp_slice #(
        .NBITS_A (A_H), .NBITS_B (B_H), .NBITS_ACC (ACC_H),
        .NBITS_Z (Z_H), .NBITS_COEF (COEF_H), .NBITS_AF (AF_H),
        .COEF_0 (COEFF_0[COEF_H-1:0]), .COEF_1 (COEFF_1[COEF_H-1:0]),
        .COEF_2 (COEFF_2[COEF_H-1:0]), .COEF_3 (COEFF_3[COEF_H-1:0])
    ) u_frac0 (
        .clock_i (clk), .reset_i (reset_i), .a_i (a_i[A_H-1:0]), .b_i (b_i[B_H-1:0]),
        .acc_fir_i (acc_fir_i[AF_H-1:0]), .ctrl_i (ctrl_i),
        .z_o (frac0_z), .dly_b_o (frac0_dly_b)
    );

    // High halves.
    dsp_slice #(
        .NBITS_A (A_H), .NBITS_B (B_H), .NBITS_ACC (ACC_H),
        .NBITS_Z (Z_H), .NBITS_COEF (COEF_H), .NBITS_AF (AF_H),
        .COEF_0 (COEFF_0[NBITS_COEF-1:COEF_H]), .COEF_1 (COEFF_1[NBITS_COEF-1:COEF_H]),
        .COEF_2 (COEFF_2[NBITS_COEF-1:COEF_H]), .COEF_3 (COEFF_3[NBITS_COEF-1:COEF_H])
    ) u_frac1 (
        .clock_i (clk), .reset_i (reset_i),
        .a_i (a_i[NBITS_A-1:A_H]), .b_i (b_i[NBITS_B-1:B_H]),
        .acc_fir_i (acc_fir_i[NBITS_AF-1:AF_H]), .ctrl_i (ctrl_i),
        .z_o (frac1_z), .dly_b_o (frac1_dly_b)
    );

    always_comb begin
        if (f_mode_i) begin
            z_o.halves.hi     = frac1_z;
            z_o.halves.lo     = frac0_z;
            dly_b_o.halves.hi = frac1_dly_b;
            dly_b_o.halves.lo = frac0_dly_b;
        end else begin
            z_o.full     = full_z;
            dly_b_o.full = full_dly_b;
        end
    end

endmodule

/* logic/dsp_mac_accumulator.sv */
`timescale 1ns/1ps

module dsp_mac_accumulator #(
    parameter int NBITS_A   = 20,
    parameter int NBITS_B   = 18,
    parameter int NBITS_ACC = 64,
    parameter int NBITS_AF  = 4
) (
    input  logic                        clock_i,
    input  logic                        reset_i,
    input  logic [NBITS_A:0]            mul_x_i,
    input  logic [NBITS_B:0]            mul_y_i,
    input  logic [1:0]                  pass_i,
    input  logic [NBITS_AF-1:0]         shift_i,
    input  dsp_pkg::dsp_ctrl_t          ctrl_i,
    output logic signed [NBITS_ACC-1:0] acc_o,
    output logic signed [NBITS_ACC-1:0] addend_o
);
    import dsp_pkg::*;

    // Product of the two extended operands.
    localparam int NBITS_P = NBITS_A + NBITS_B + 2;

    logic signed [NBITS_P-1:0]   product;
    logic signed [NBITS_ACC-1:0] term;
    logic signed [NBITS_ACC-1:0] shifted;
    logic signed [NBITS_ACC-1:0] addend;
    logic signed [NBITS_ACC-1:0] acc_next;
    logic signed [NBITS_ACC-1:0] acc_q;
    logic signed [NBITS_ACC-1:0] addend_q;

    assign product = $signed(mul_x_i) * $signed(mul_y_i);

    // Sign extend the chosen source to accumulator width.
    always_comb begin
        case (pass_i)
            ADD_PASS_X: begin
                term = {{(NBITS_ACC-NBITS_A-1){mul_x_i[NBITS_A]}}, mul_x_i};
            end
            ADD_PASS_Y: begin
                term = {{(NBITS_ACC-NBITS_B-1){mul_y_i[NBITS_B]}}, mul_y_i};
            end
            ADD_ZERO: begin
                term = '0;
            end
            default: begin
                term = {{(NBITS_ACC-NBITS_P){product[NBITS_P-1]}}, product};
            end
        endcase
    end

    always_comb begin
        shifted = term <<< shift_i;                     // FIR tap weighting.
        addend  = ctrl_i.subtract ? -shifted : shifted;
        if (ctrl_i.load_acc) begin
            acc_next = acc_q + addend;
        end else begin
            acc_next = addend;                          // Start a new sum.
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            acc_q    <= '0;
            addend_q <= '0;
        end else begin
            acc_q    <= acc_next;
            addend_q <= addend;
        end
    end

    assign acc_o    = acc_q;
    assign addend_o = addend_q;

endmodule

/* logic/dsp_operand_stage.sv */
`timescale 1ns/1ps

module dsp_operand_stage #(
    parameter int                    NBITS_A    = 20,
    parameter int                    NBITS_B    = 18,
    parameter int                    NBITS_COEF = 20,
    parameter int                    NBITS_AF   = 4,
    parameter logic [NBITS_COEF-1:0] COEF_0     = '0,
    parameter logic [NBITS_COEF-1:0] COEF_1     = '0,
    parameter logic [NBITS_COEF-1:0] COEF_2     = '0,
    parameter logic [NBITS_COEF-1:0] COEF_3     = '0
) (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic [NBITS_A-1:0]  a_i,
    input  logic [NBITS_B-1:0]  b_i,
    input  logic [NBITS_AF-1:0] acc_fir_i,
    input  dsp_pkg::dsp_ctrl_t  ctrl_i,
    output logic [NBITS_A:0]    mul_x_o,
    output logic [NBITS_B:0]    mul_y_o,
    output logic [1:0]          pass_o,
    output logic [NBITS_AF-1:0] shift_o,
    output dsp_pkg::dsp_ctrl_t  ctrl_o,
    output logic [NBITS_B-1:0]  dly_b_o
);
    import dsp_pkg::*;

    logic [NBITS_A-1:0]  a_q;
    logic [NBITS_B-1:0]  b_q;
    logic [NBITS_AF-1:0] af_q;
    dsp_ctrl_t           ctrl_q;
    logic [NBITS_A-1:0]  a_s;
    logic [NBITS_B-1:0]  b_s;
    dsp_ctrl_t           ctrl_s;
    logic [NBITS_A-1:0]  x_sel;
    logic [NBITS_B-1:0]  dly_b_q;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            a_q    <= '0;
            b_q    <= '0;
            af_q   <= '0;
            ctrl_q <= '0;
        end else begin
            a_q    <= a_i;
            b_q    <= b_i;
            af_q   <= acc_fir_i;
            ctrl_q <= ctrl_i;
        end
    end

    // Register mode is a static setting, so the live bit picks the path.
    assign a_s     = ctrl_i.register_inputs ? a_q : a_i;
    assign b_s     = ctrl_i.register_inputs ? b_q : b_i;
    assign shift_o = ctrl_i.register_inputs ? af_q : acc_fir_i;
    assign ctrl_s  = ctrl_i.register_inputs ? ctrl_q : ctrl_i;

    always_comb begin
        case (ctrl_s.feedback)
            FB_COEF0: x_sel = NBITS_A'(COEF_0);
            FB_COEF1: x_sel = NBITS_A'(COEF_1);
            FB_COEF2: x_sel = NBITS_A'(COEF_2);
            FB_COEF3: x_sel = NBITS_A'(COEF_3);
            default:  x_sel = a_s;
        endcase
        case (ctrl_s.feedback)
            FB_PASS_A: pass_o = ADD_PASS_X;
            FB_PASS_B: pass_o = ADD_PASS_Y;
            FB_ZERO:   pass_o = ADD_ZERO;
            default:   pass_o = ADD_PRODUCT;
        endcase
    end

    // One extra bit lets unsigned operands go through a signed multiplier.
    assign mul_x_o = {~ctrl_s.unsigned_a & x_sel[NBITS_A-1], x_sel};
    assign mul_y_o = {~ctrl_s.unsigned_b & b_s[NBITS_B-1], b_s};
    assign ctrl_o  = ctrl_s;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            dly_b_q <= '0;
        end else begin
            dly_b_q <= b_s;     // Cascade copy of B.
        end
    end

    assign dly_b_o = dly_b_q;

endmodule

/* logic/dsp_output_stage.sv */
`timescale 1ns/1ps

module dsp_output_stage #(
    parameter int NBITS_ACC = 64,
    parameter int NBITS_Z   = 38
) (
    input  logic                        clock_i,
    input  logic                        reset_i,
    input  logic signed [NBITS_ACC-1:0] acc_i,
    input  logic signed [NBITS_ACC-1:0] addend_i,
    input  dsp_pkg::dsp_ctrl_t          ctrl_i,
    output logic [NBITS_Z-1:0]          z_o
);
    import dsp_pkg::*;

    // Signed limits of z in a word one bit wider than the accumulator.
    localparam logic signed [NBITS_ACC:0] Z_MAX =
        {{(NBITS_ACC-NBITS_Z+2){1'b0}}, {(NBITS_Z-1){1'b1}}};
    localparam logic signed [NBITS_ACC:0] Z_MIN =
        {{(NBITS_ACC-NBITS_Z+2){1'b1}}, {(NBITS_Z-1){1'b0}}};

    logic signed [NBITS_ACC-1:0] src;
    logic signed [NBITS_ACC:0]   rnd_bit;
    logic signed [NBITS_ACC:0]   rounded;
    logic signed [NBITS_ACC:0]   shifted;
    logic [NBITS_Z-1:0]          z_d;
    logic [NBITS_Z-1:0]          z_q;

    always_comb begin
        case (ctrl_i.output_select)
            OSEL_ADDEND: src = addend_i;
            OSEL_ACC:    src = acc_i;
            default:     src = acc_i;
        endcase
    end

    always_comb begin
        rnd_bit = '0;
        if (ctrl_i.round && (ctrl_i.shift_right != 6'd0)) begin
            rnd_bit = {{NBITS_ACC{1'b0}}, 1'b1} << (ctrl_i.shift_right - 6'd1);
        end
        rounded = {src[NBITS_ACC-1], src} + rnd_bit;    // Extra bit absorbs the carry.
        if (ctrl_i.shift_right >= NBITS_ACC) begin
            shifted = {(NBITS_ACC+1){src[NBITS_ACC-1]}};
        end else begin
            shifted = rounded >>> ctrl_i.shift_right;
        end
    end

    always_comb begin
        if (ctrl_i.output_select == OSEL_RAW) begin
            z_d = acc_i[NBITS_Z-1:0];                   // No shift, no clamp.
        end else if (ctrl_i.saturate_enable && (shifted > Z_MAX)) begin
            z_d = Z_MAX[NBITS_Z-1:0];
        end else if (ctrl_i.saturate_enable && (shifted < Z_MIN)) begin
            z_d = Z_MIN[NBITS_Z-1:0];
        end else begin
            z_d = shifted[NBITS_Z-1:0];
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            z_q <= '0;
        end else begin
            z_q <= z_d;
        end
    end

    assign z_o = z_q;

    // The control word comes from outside the slice.
    a_osel_legal: assert property (@(posedge clock_i) disable iff (reset_i)
        ctrl_i.output_select <= OSEL_ADDEND)
    else $error("illegal output_select %0d", ctrl_i.output_select);

endmodule

/* logic/dsp_pkg.sv */
package dsp_pkg;

    // Full-width datapath sizes. A fractured half uses half of each.
    localparam int NBITS_A    = 20;
    localparam int NBITS_B    = 18;
    localparam int NBITS_Z    = 38;
    localparam int NBITS_ACC  = 64;
    localparam int NBITS_COEF = 20;
    localparam int NBITS_AF   = 4;

    // Feedback codes select what goes into the accumulator.
    localparam logic [2:0] FB_AB     = 3'd0;
    localparam logic [2:0] FB_COEF0  = 3'd1;
    localparam logic [2:0] FB_COEF1  = 3'd2;
    localparam logic [2:0] FB_COEF2  = 3'd3;
    localparam logic [2:0] FB_COEF3  = 3'd4;
    localparam logic [2:0] FB_PASS_A = 3'd5;
    localparam logic [2:0] FB_PASS_B = 3'd6;
    localparam logic [2:0] FB_ZERO   = 3'd7;

    // Output select codes. 3 to 7 are not legal.
    localparam logic [2:0] OSEL_ACC    = 3'd0;
    localparam logic [2:0] OSEL_RAW    = 3'd1;
    localparam logic [2:0] OSEL_ADDEND = 3'd2;

    // Addend source as the operand stage decodes it from feedback.
    localparam logic [1:0] ADD_PRODUCT = 2'd0;
    localparam logic [1:0] ADD_PASS_X  = 2'd1;
    localparam logic [1:0] ADD_PASS_Y  = 2'd2;
    localparam logic [1:0] ADD_ZERO    = 2'd3;

    typedef struct packed {
        logic [2:0] feedback;
        logic       load_acc;        // Set adds into the accumulator, clear loads it.
        logic       unsigned_a;
        logic       unsigned_b;
        logic [2:0] output_select;
        logic       saturate_enable;
        logic [5:0] shift_right;
        logic       round;
        logic       subtract;
        logic       register_inputs;
    } dsp_ctrl_t;

    typedef struct packed {
        logic [NBITS_Z/2-1:0] hi;
        logic [NBITS_Z/2-1:0] lo;
    } dsp_z_halves_t;

    typedef union packed {
        logic [NBITS_Z-1:0] full;
        dsp_z_halves_t      halves;
    } dsp_z_u;

    typedef struct packed {
        logic [NBITS_B/2-1:0] hi;
        logic [NBITS_B/2-1:0] lo;
    } dsp_dly_b_halves_t;

    typedef union packed {
        logic [NBITS_B-1:0] full;
        dsp_dly_b_halves_t  halves;
    } dsp_dly_b_u;

endpackage

/* logic/dsp_slice.sv */
`timescale 1ns/1ps

module dsp_slice #(
    parameter int                    NBITS_A    = 20,
    parameter int                    NBITS_B    = 18,
    parameter int                    NBITS_ACC  = 64,
    parameter int                    NBITS_Z    = 38,
    parameter int                    NBITS_COEF = 20,
    parameter int                    NBITS_AF   = 4,
    parameter logic [NBITS_COEF-1:0] COEF_0     = '0,
    parameter logic [NBITS_COEF-1:0] COEF_1     = '0,
    parameter logic [NBITS_COEF-1:0] COEF_2     = '0,
    parameter logic [NBITS_COEF-1:0] COEF_3     = '0
) (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic [NBITS_A-1:0]  a_i,
    input  logic [NBITS_B-1:0]  b_i,
    input  logic [NBITS_AF-1:0] acc_fir_i,
    input  dsp_pkg::dsp_ctrl_t  ctrl_i,
    output logic [NBITS_Z-1:0]  z_o,
    output logic [NBITS_B-1:0]  dly_b_o
);
    import dsp_pkg::*;

    logic [NBITS_A:0]            mul_x;
    logic [NBITS_B:0]            mul_y;
    logic [1:0]                  pass;
    logic [NBITS_AF-1:0]         shift;
    dsp_ctrl_t                   stage_ctrl;    // Control aligned with the operands.
    logic signed [NBITS_ACC-1:0] acc;
    logic signed [NBITS_ACC-1:0] addend;

    dsp_operand_stage #(
        .NBITS_A    (NBITS_A),
        .NBITS_B    (NBITS_B),
        .NBITS_COEF (NBITS_COEF),
        .NBITS_AF   (NBITS_AF),
        .COEF_0     (COEF_0),
        .COEF_1     (COEF_1),
        .COEF_2     (COEF_2),
        .COEF_3     (COEF_3)
    ) u_operand (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .acc_fir_i (acc_fir_i),
        .ctrl_i    (ctrl_i),
        .mul_x_o   (mul_x),
        .mul_y_o   (mul_y),
        .pass_o    (pass),
        .shift_o   (shift),
        .ctrl_o    (stage_ctrl),
        .dly_b_o   (dly_b_o)
    );

    dsp_mac_accumulator #(
        .NBITS_A   (NBITS_A),
        .NBITS_B   (NBITS_B),
        .NBITS_ACC (NBITS_ACC),
        .NBITS_AF  (NBITS_AF)
    ) u_mac (
        .clock_i  (clock_i),
        .reset_i  (reset_i),
        .mul_x_i  (mul_x),
        .mul_y_i  (mul_y),
        .pass_i   (pass),
        .shift_i  (shift),
        .ctrl_i   (stage_ctrl),
        .acc_o    (acc),
        .addend_o (addend)
    );

    // Output controls act on the accumulator as it stands.
    dsp_output_stage #(
        .NBITS_ACC (NBITS_ACC),
        .NBITS_Z   (NBITS_Z)
    ) u_output (
        .clock_i  (clock_i),
        .reset_i  (reset_i),
        .acc_i    (acc),
        .addend_i (addend),
        .ctrl_i   (stage_ctrl),
        .z_o      (z_o)
    );

    // Largest shifted product must fit in the accumulator.
    a_acc_width: assert property (@(posedge clock_i)
        (NBITS_A + NBITS_B + 2 + (2 ** NBITS_AF) - 1) <= NBITS_ACC)
    else $error("accumulator too narrow for product and shift");

endmodule

/* sim/tb_dsp_fracturable.sv */
`timescale 1ns/1ps

module tb_dsp_fracturable;
    import dsp_pkg::*;

    localparam int PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int N_PROD = 12;         // Per signedness combination.
    localparam int N_ACC = 40;
    localparam int N_SAT = 10;
    localparam int N_MIXED = 16;
    localparam int N_BYPASS = 12;
    localparam int N_FRAC = 40;
    localparam int N_REG = 16;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 4 * N_PROD + N_ACC + 3 * N_SAT + N_MIXED
                                + N_BYPASS + N_FRAC + N_REG;
    localparam logic [19:0] COEFFS [4] = '{20'h1F3A5, 20'h80402, 20'h7FE01, 20'hC0F3B};

    typedef logic signed [65:0] val_t;

    typedef struct packed {
        logic [19:0] a;
        logic [17:0] b;
        logic [3:0]  af;
        dsp_ctrl_t   ctrl;
    } in_t;

    logic        clk;
    logic        reset_i;
    logic [19:0] a_i;
    logic [17:0] b_i;
    logic [3:0]  acc_fir_i;
    dsp_ctrl_t   ctrl_i;
    logic        f_mode_i;
    dsp_z_u      z_o;
    dsp_dly_b_u  dly_b_o;

    // Model state per slice. 0 is full, 1 the low half, 2 the high half.
    in_t         m_in_q [3];
    val_t        m_acc [3];
    val_t        m_add [3];
    val_t        m_z [3];
    logic [17:0] m_dly [3];

    logic [31:0] lcg_state = 32'h7755_d9f0;
    int n_checks = 0;
    int n_errors = 0;
    int n_tests = 0;
    int n_tests_failed = 0;

    dsp_fracturable #(
        .COEFF_0 (COEFFS[0]), .COEFF_1 (COEFFS[1]),
        .COEFF_2 (COEFFS[2]), .COEFF_3 (COEFFS[3])
    ) u_dsp_fracturable (
        .clk (clk), .reset_i (reset_i), .a_i (a_i), .b_i (b_i), .acc_fir_i (acc_fir_i),
        .ctrl_i (ctrl_i), .f_mode_i (f_mode_i), .z_o (z_o), .dly_b_o (dly_b_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(2 * TOTAL_CYCLES * PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    // Low LCG bits have short periods. The high half goes to the low end.
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic dsp_ctrl_t make_ctrl(input logic [2:0] fb, input logic load,
                                            input logic ua, input logic ub,
                                            input logic [2:0] osel, input logic sat,
                                            input logic [5:0] sr, input logic rnd,
                                            input logic sub, input logic reg_in);
        dsp_ctrl_t c;
        c.feedback = fb;
        c.load_acc = load;
        c.unsigned_a = ua;
        c.unsigned_b = ub;
        c.output_select = osel;
        c.saturate_enable = sat;
        c.shift_right = sr;
        c.round = rnd;
        c.subtract = sub;
        c.register_inputs = reg_in;
        return c;
    endfunction

    // Keeps the low n bits as a signed value.
    function automatic val_t wrap_to(input val_t v, input int n);
        return (v <<< (66 - n)) >>> (66 - n);
    endfunction

    function automatic val_t extend_operand(input logic [19:0] x, input int n, input logic uns);
        val_t v;
        v = val_t'(x) & ((val_t'(1) <<< n) - 1);
        if (!uns && x[n-1]) v = v - (val_t'(1) <<< n);
        return v;
    endfunction

    function automatic val_t shape_output(input val_t acc, input val_t add, input dsp_ctrl_t c,
                                          input int nacc, input int nz);
        val_t s;
        val_t r;
        val_t lim;
        if (c.output_select == OSEL_RAW) return acc;
        s = (c.output_select == OSEL_ADDEND) ? add : acc;
        r = s;
        if (c.round && c.shift_right != 0) r = r + (val_t'(1) <<< (c.shift_right - 1));
        if (c.shift_right >= nacc) r = (s < 0) ? -1 : 0;
        else r = r >>> c.shift_right;
        lim = val_t'(1) <<< (nz - 1);
        if (c.saturate_enable && r > lim - 1) r = lim - 1;
        if (c.saturate_enable && r < -lim) r = -lim;
        return r;
    endfunction

    task automatic model_slice_cycle(input int s, input in_t cur);
        in_t         eff;
        logic [19:0] x;
        val_t        term;
        val_t        addend;
        int          na;
        int          nacc;
        na = (s == 0) ? 20 : 10;
        nacc = (s == 0) ? 64 : 32;
        eff = cur.ctrl.register_inputs ? m_in_q[s] : cur;
        m_in_q[s] = cur;
        x = eff.a;
        if (eff.ctrl.feedback inside {[FB_COEF0:FB_COEF3]}) begin
            x = COEFFS[eff.ctrl.feedback - 1];
            if (s == 1) x = {10'd0, x[9:0]};
            if (s == 2) x = {10'd0, x[19:10]};
        end
        case (eff.ctrl.feedback)
            FB_PASS_A: term = extend_operand(x, na, eff.ctrl.unsigned_a);
            FB_PASS_B: term = extend_operand(eff.b, (s == 0) ? 18 : 9, eff.ctrl.unsigned_b);
            FB_ZERO:   term = 0;
            default:   term = extend_operand(x, na, eff.ctrl.unsigned_a)
                            * extend_operand(eff.b, (s == 0) ? 18 : 9, eff.ctrl.unsigned_b);
        endcase
        term = term <<< eff.af;
        addend = wrap_to(eff.ctrl.subtract ? -term : term, nacc);
        m_z[s] = shape_output(m_acc[s], m_add[s], eff.ctrl, nacc, (s == 0) ? 38 : 19);
        m_acc[s] = eff.ctrl.load_acc ? wrap_to(m_acc[s] + addend, nacc) : addend;
        m_add[s] = addend;
        m_dly[s] = eff.b;
    endtask

    task automatic check_z(input string name, input dsp_z_u exp_z, input dsp_z_u act_z);
        n_checks++;
        if (act_z !== exp_z) begin
            n_errors++;
            $display("[FAIL] %s: z expected 0x%h actual 0x%h", name, exp_z, act_z);
        end
    endtask

    task automatic check_dly_b(input string name, input dsp_dly_b_u exp_d,
                               input dsp_dly_b_u act_d);
        n_checks++;
        if (act_d !== exp_d) begin
            n_errors++;
            $display("[FAIL] %s: dly_b expected 0x%h actual 0x%h", name, exp_d, act_d);
        end
    endtask

    // Called at a falling edge. Drives one sample and checks after the next rising edge.
    task automatic apply_cycle(input string name, input logic [19:0] a, input logic [17:0] b,
                               input logic [3:0] af, input dsp_ctrl_t c, input logic f);
        dsp_z_u     exp_z;
        dsp_dly_b_u exp_d;
        a_i = a;
        b_i = b;
        acc_fir_i = af;
        ctrl_i = c;
        f_mode_i = f;
        model_slice_cycle(0, '{a, b, af, c});
        model_slice_cycle(1, '{{10'd0, a[9:0]}, {9'd0, b[8:0]}, {2'd0, af[1:0]}, c});
        model_slice_cycle(2, '{{10'd0, a[19:10]}, {9'd0, b[17:9]}, {2'd0, af[3:2]}, c});
        if (f) begin
            exp_z.halves.hi = m_z[2][18:0];
            exp_z.halves.lo = m_z[1][18:0];
            exp_d.halves.hi = m_dly[2][8:0];
            exp_d.halves.lo = m_dly[1][8:0];
        end else begin
            exp_z.full = m_z[0][37:0];
            exp_d.full = m_dly[0];
        end
        @(negedge clk);
        check_z(name, exp_z, z_o);
        check_dly_b(name, exp_d, dly_b_o);
    endtask

    task automatic report_test(input string name, input int errors_before);
        n_tests++;
        if (n_errors == errors_before) begin
            $display("%-24s passed", name);
        end else begin
            n_tests_failed++;
            $display("%-24s failed with %0d mismatches", name, n_errors - errors_before);
        end
    endtask

    task automatic full_width_products();
        int e0;
        e0 = n_errors;
        check_z("reset", '0, z_o);
        check_dly_b("reset", '0, dly_b_o);
        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < N_PROD; i++) begin
                apply_cycle("full_product", next_random(), next_random(), 4'd0,
                            make_ctrl(FB_AB, 0, m[0], m[1], OSEL_ACC, 0, 0, 0, 0, 0), 0);
            end
        end
        report_test("full_product", e0);
    endtask

    task automatic coefficient_accumulation();
        int e0;
        e0 = n_errors;
        for (int i = 0; i < N_ACC; i++) begin
            apply_cycle("coef_accumulate", next_random(), next_random(), next_random(),
                        make_ctrl(next_random() % 5, i % 8 != 0, 0, 0, OSEL_ACC, 0, 0, 0,
                                  next_random(), 0), 0);
        end
        report_test("coef_accumulate", e0);
    endtask

    task automatic output_processing();
        int e0;
        e0 = n_errors;
        // Drive the accumulator far past both ends of the z range.
        for (int i = 0; i < N_SAT; i++) begin
            apply_cycle("output_process", 20'h7FFFF, 18'h1FFFF, 4'd15,
                        make_ctrl(FB_AB, 1, 0, 0, OSEL_ACC, 1, 6'd4, 1, 0, 0), 0);
        end
        for (int i = 0; i < 2 * N_SAT; i++) begin
            apply_cycle("output_process", 20'h7FFFF, 18'h1FFFF, 4'd15,
                        make_ctrl(FB_AB, 1, 0, 0, OSEL_ACC, 1, 6'd4, 1, 1, 0), 0);
        end
        for (int i = 0; i < N_MIXED; i++) begin
            apply_cycle("output_process", next_random(), next_random(), next_random(),
                        make_ctrl(next_random() % 5, next_random(), 0, 0, next_random() % 3,
                                  next_random(), next_random(), next_random(),
                                  next_random(), 0), 0);
        end
        report_test("output_process", e0);
    endtask

    task automatic bypass_codes();
        logic [2:0] codes [3] = '{FB_PASS_A, FB_PASS_B, FB_ZERO};
        int e0;
        e0 = n_errors;
        for (int i = 0; i < N_BYPASS; i++) begin
            apply_cycle("bypass", next_random(), next_random(), 4'd0,
                        make_ctrl(codes[i % 3], 0, next_random(), next_random(), OSEL_ACC,
                                  0, 0, 0, 0, 0), 0);
        end
        report_test("bypass", e0);
    endtask

    task automatic fractured_mode();
        int e0;
        e0 = n_errors;
        for (int i = 0; i < N_FRAC; i++) begin
            apply_cycle("fractured", next_random(), next_random(), next_random(),
                        make_ctrl(next_random(), next_random(), next_random(), next_random(),
                                  next_random() % 3, next_random(), next_random() % 24,
                                  next_random(), next_random(), 0), 1);
        end
        report_test("fractured", e0);
    endtask

    task automatic registered_inputs();
        int e0;
        e0 = n_errors;
        for (int i = 0; i < N_REG; i++) begin
            apply_cycle("registered_inputs", next_random(), next_random(), 4'd0,
                        make_ctrl(FB_AB, 0, i[0], i[1], OSEL_ACC, 0, 0, 0, 0, 1), 0);
        end
        report_test("registered_inputs", e0);
    endtask

    initial begin
        reset_i = 1'b1;
        a_i = '0;
        b_i = '0;
        acc_fir_i = '0;
        ctrl_i = '0;
        f_mode_i = 1'b0;
        for (int s = 0; s < 3; s++) begin
            m_in_q[s] = '0;
            m_acc[s] = 0;
            m_add[s] = 0;
            m_z[s] = 0;
            m_dly[s] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        full_width_products();
        coefficient_accumulation();
        output_processing();
        bypass_codes();
        fractured_mode();
        registered_inputs();
        $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
                 n_tests, n_tests_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
